// ==== design/issue_queue_mem_defines.svh ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Memory issue queue sizing
// Depth, dispatch width, tag bus width and the
// register tag and reorder buffer id widths
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`ifndef ISSUE_QUEUE_MEM_DEFINES_SVH
`define ISSUE_QUEUE_MEM_DEFINES_SVH

// Number of queue slots
`define IQ_MEM_SIZE 8

// Micro-ops offered by dispatch per cycle
`define DISPATCH_WIDTH 2

// Tags broadcast on the common tag bus per cycle
`define CTB_WIDTH 2

// Physical register tag width
`define PRF_TAG_SIZE 6

// Reorder buffer id width
`define ROB_ID_SIZE 5

`endif

// ==== design/issue_queue_pkg.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Memory issue queue types
// Micro-op, tag bus broadcast and slot index
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

`include "issue_queue_mem_defines.svh"

package issue_queue_pkg;

  // Memory micro-op as held by dispatch and by each slot
  typedef struct packed {
    logic                       valid;
    logic                       is_store;
    // Operand 1 waits on a producer
    logic                       rs1_wait;
    logic [`PRF_TAG_SIZE-1:0]   rs1_tag;
    // Operand 2 waits on a producer
    logic                       rs2_wait;
    logic [`PRF_TAG_SIZE-1:0]   rs2_tag;
    logic [`ROB_ID_SIZE-1:0]    rob_id;
  } mem_uop_t;

  // One broadcast on the common tag bus
  typedef struct packed {
    logic                       valid;
    logic [`PRF_TAG_SIZE-1:0]   tag;
  } ctb_t;

  // Slot number, slot 0 is the oldest
  typedef logic [$clog2(`IQ_MEM_SIZE)-1:0] slot_index_t;

endpackage

`default_nettype wire

// ==== design/issue_slot_mem.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Memory issue queue slot
// Holds one micro-op and tracks operand wake-up
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

`include "issue_queue_mem_defines.svh"

module issue_slot_mem (
  input  wire logic                                     clock,
  input  wire logic                                     reset,
  input  wire issue_queue_pkg::ctb_t [`CTB_WIDTH-1:0]   ctb,
  input  wire logic                                     load,
  input  wire issue_queue_pkg::mem_uop_t                uop_new,
  input  wire logic                                     shift,
  input  wire issue_queue_pkg::mem_uop_t                uop_above,
  input  wire logic [1:0]                               rdy_above,
  input  wire logic                                     clear,
  output issue_queue_pkg::mem_uop_t                     uop,
  output logic [1:0]                                    rdy,
  output logic                                          ready,
  output logic                                          occupied
);

  import issue_queue_pkg::*;

  mem_uop_t   src_uop;
  logic [1:0] src_rdy;
  mem_uop_t   uop_next;
  logic [1:0] rdy_next;

  // True when a valid broadcast carries this tag
  function automatic logic tag_hit(input logic [`PRF_TAG_SIZE-1:0] tag);
    logic hit;
    hit = 1'b0;
    for (int i = 0; i < `CTB_WIDTH; i++) begin
      if (ctb[i].valid && (ctb[i].tag == tag)) begin
        hit = 1'b1;
      end
    end
    return hit;
  endfunction

  // Pick the source of the next contents, then apply wake-up to it
  always_comb begin
    if (load) begin
      src_uop = uop_new;
      src_rdy = {~uop_new.rs2_wait, ~uop_new.rs1_wait};
    end else if (shift) begin
      src_uop = uop_above;
      src_rdy = rdy_above;
    end else begin
      src_uop = uop;
      src_rdy = rdy;
    end

    uop_next    = src_uop;
    rdy_next[0] = src_rdy[0] | tag_hit(src_uop.rs1_tag);
    rdy_next[1] = src_rdy[1] | tag_hit(src_uop.rs2_tag);

    // Vacated by issue with nothing moving in
    if (clear && !load && !shift) begin
      uop_next.valid = 1'b0;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      uop.valid <= 1'b0;
      rdy       <= '0;
    end else begin
      uop <= uop_next;
      rdy <= rdy_next;
    end
  end

  assign occupied = uop.valid;
  assign ready    = uop.valid & rdy[0] & rdy[1];

endmodule

`default_nettype wire

// ==== design/issue_select_mem.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Memory issue queue selector
// Picks the oldest issuable slot, stores only
// from slot 0
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

`include "issue_queue_mem_defines.svh"

module issue_select_mem (
  input  wire logic [`IQ_MEM_SIZE-1:0]  ready,
  input  wire logic [`IQ_MEM_SIZE-1:0]  is_store,
  input  wire logic                     ex_busy,
  output issue_queue_pkg::slot_index_t  sel,
  output logic                          sel_valid
);

  import issue_queue_pkg::*;

  logic [`IQ_MEM_SIZE-1:0] eligible;

  // A store may only leave once every older memory op has gone,
  // which is exactly when it reaches slot 0
  always_comb begin
    eligible = ready;
    for (int i = 1; i < `IQ_MEM_SIZE; i++) begin
      if (is_store[i]) begin
        eligible[i] = 1'b0;
      end
    end

    // Execute cannot take anything this cycle
    if (ex_busy) begin
      eligible = '0;
    end
  end

  // Priority encoder, lowest slot wins
  always_comb begin
    sel       = '0;
    sel_valid = 1'b0;
    for (int i = `IQ_MEM_SIZE - 1; i >= 0; i--) begin
      if (eligible[i]) begin
        sel       = slot_index_t'(i);
        sel_valid = 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// ==== design/issue_queue_mem.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Memory issue queue
// Compressing queue between dispatch and the
// load/store unit, one issue per cycle
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

`include "issue_queue_mem_defines.svh"

module issue_queue_mem (
  input  wire logic                                           clock,
  input  wire logic                                           reset,
  input  wire issue_queue_pkg::mem_uop_t [`DISPATCH_WIDTH-1:0] dispatch_uop,
  input  wire issue_queue_pkg::ctb_t [`CTB_WIDTH-1:0]         ctb,
  input  wire logic                                           ex_busy,
  output issue_queue_pkg::mem_uop_t                           issue_uop,
  output logic                                                iq_full
);

  import issue_queue_pkg::*;

  // Occupancy runs from 0 to IQ_MEM_SIZE inclusive
  localparam int count_width = $clog2(`IQ_MEM_SIZE + 1);

  mem_uop_t [`IQ_MEM_SIZE-1:0]      slot_uop;
  mem_uop_t [`IQ_MEM_SIZE-1:0]      slot_uop_new;
  logic [`IQ_MEM_SIZE-1:0][1:0]     slot_rdy;
  logic [`IQ_MEM_SIZE-1:0]          slot_load;
  logic [`IQ_MEM_SIZE-1:0]          slot_shift;
  logic [`IQ_MEM_SIZE-1:0]          slot_clear;
  logic [`IQ_MEM_SIZE-1:0]          slot_ready;
  logic [`IQ_MEM_SIZE-1:0]          slot_occupied;
  logic [`IQ_MEM_SIZE-1:0]          slot_is_store;

  slot_index_t                      sel;
  logic                             sel_valid;

  logic [count_width-1:0]           count;
  logic [count_width-1:0]           count_next;
  logic [count_width-1:0]           dispatch_count;

  // Slot array, each slot sees its upper neighbour for compression
  for (genvar k = 0; k < `IQ_MEM_SIZE; k++) begin : g_slot
    mem_uop_t   above_uop;
    logic [1:0] above_rdy;

    if (k < `IQ_MEM_SIZE - 1) begin : g_above
      assign above_uop = slot_uop[k+1];
      assign above_rdy = slot_rdy[k+1];
    end else begin : g_top
      // Nothing sits above the top slot
      assign above_uop = '0;
      assign above_rdy = '0;
    end

    issue_slot_mem issue_slot_mem_inst (
      .clock     (clock),
      .reset     (reset),
      .ctb       (ctb),
      .load      (slot_load[k]),
      .uop_new   (slot_uop_new[k]),
      .shift     (slot_shift[k]),
      .uop_above (above_uop),
      .rdy_above (above_rdy),
      .clear     (slot_clear[k]),
      .uop       (slot_uop[k]),
      .rdy       (slot_rdy[k]),
      .ready     (slot_ready[k]),
      .occupied  (slot_occupied[k])
    );

    assign slot_is_store[k] = slot_occupied[k] & slot_uop[k].is_store;
  end

  issue_select_mem issue_select_mem_inst (
    .ready     (slot_ready),
    .is_store  (slot_is_store),
    .ex_busy   (ex_busy),
    .sel       (sel),
    .sel_valid (sel_valid)
  );

  // Issue mux
  assign issue_uop = sel_valid ? slot_uop[sel] : '0;

  // The issued slot and every slot above it are vacated; all but the
  // top one refill from their upper neighbour
  always_comb begin
    slot_clear = '0;
    slot_shift = '0;
    for (int k = 0; k < `IQ_MEM_SIZE; k++) begin
      if (sel_valid && (slot_index_t'(k) >= sel)) begin
        slot_clear[k] = 1'b1;
        if (k < `IQ_MEM_SIZE - 1) begin
          slot_shift[k] = 1'b1;
        end
      end
    end
  end

  // Allocation
  // Valid lanes are packed in lane order just above the occupants
  // that remain after this cycle's issue
  always_comb begin
    logic [count_width-1:0] pos;

    pos            = count - count_width'(sel_valid);
    dispatch_count = '0;
    slot_load      = '0;
    slot_uop_new   = '0;
    for (int i = 0; i < `DISPATCH_WIDTH; i++) begin
      if (dispatch_uop[i].valid) begin
        if (pos < count_width'(`IQ_MEM_SIZE)) begin
          slot_load[slot_index_t'(pos)]    = 1'b1;
          slot_uop_new[slot_index_t'(pos)] = dispatch_uop[i];
        end
        pos            = pos + 1'b1;
        dispatch_count = dispatch_count + 1'b1;
      end
    end
  end

  // Occupancy count
  assign count_next = count - count_width'(sel_valid) + dispatch_count;

  always_ff @(posedge clock) begin
    if (reset) begin
      count <= '0;
    end else begin
      count <= count_next;
    end
  end

  // Full when fewer than a dispatch group of slots is free
  assign iq_full = count > count_width'(`IQ_MEM_SIZE - `DISPATCH_WIDTH);

endmodule

`default_nettype wire

// ==== dv/issue_queue_mem_props.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Memory issue queue properties
// Port rules and occupancy bound, bound to the top
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

`include "issue_queue_mem_defines.svh"

module issue_queue_mem_props (
  input wire logic                                            clock,
  input wire logic                                            reset,
  input wire issue_queue_pkg::mem_uop_t [`DISPATCH_WIDTH-1:0] dispatch_uop,
  input wire logic                                            ex_busy,
  input wire issue_queue_pkg::mem_uop_t                       issue_uop,
  input wire logic                                            iq_full,
  input wire issue_queue_pkg::slot_index_t                    sel,
  input wire logic [$clog2(`IQ_MEM_SIZE + 1)-1:0]             count
);

  timeunit 1ns;
  timeprecision 100ps;

  import issue_queue_pkg::*;

  logic [`DISPATCH_WIDTH-1:0] dispatch_valid;

  for (genvar i = 0; i < `DISPATCH_WIDTH; i++) begin : g_lane
    assign dispatch_valid[i] = dispatch_uop[i].valid;
  end

  no_dispatch_when_full: assert property (@(posedge clock) disable iff (reset)
    iq_full |-> (dispatch_valid == '0))
    else $error("Valid dispatch while iq_full is high");

  no_issue_when_busy: assert property (@(posedge clock) disable iff (reset)
    ex_busy |-> !issue_uop.valid)
    else $error("Issue while ex_busy is high");

  // Stores leave only once they reach the oldest slot
  store_from_head: assert property (@(posedge clock) disable iff (reset)
    (issue_uop.valid && issue_uop.is_store) |-> (sel == '0))
    else $error("Store issued from a slot other than 0");

  occupancy_bound: assert property (@(posedge clock) disable iff (reset)
    count <= `IQ_MEM_SIZE)
    else $error("Occupancy count above the queue depth");

endmodule

`default_nettype wire

// ==== dv/issue_queue_mem_tb.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Memory issue queue testbench
// Directed tests for issue order, wake-up, store
// ordering and back-pressure
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

`include "issue_queue_mem_defines.svh"

module issue_queue_mem_tb;

  timeunit 1ns;
  timeprecision 100ps;

  import issue_queue_pkg::*;

  localparam int clock_period    = 4;
  localparam int test_count      = 6;
  localparam int cycles_per_test = 40;
  localparam int margin_cycles   = 20;

  logic                           clock;
  logic                           reset;
  mem_uop_t [`DISPATCH_WIDTH-1:0] dispatch_uop;
  ctb_t [`CTB_WIDTH-1:0]          ctb;
  logic                           ex_busy;
  mem_uop_t                       issue_uop;
  logic                           iq_full;

  logic [31:0] lfsr_state = 32'ha738c589;

  issue_queue_mem issue_queue_mem_inst (
    .clock        (clock),
    .reset        (reset),
    .dispatch_uop (dispatch_uop),
    .ctb          (ctb),
    .ex_busy      (ex_busy),
    .issue_uop    (issue_uop),
    .iq_full      (iq_full)
  );

  bind issue_queue_mem issue_queue_mem_props issue_queue_mem_props_inst (
    .clock        (clock),
    .reset        (reset),
    .dispatch_uop (dispatch_uop),
    .ex_busy      (ex_busy),
    .issue_uop    (issue_uop),
    .iq_full      (iq_full),
    .sel          (sel),
    .count        (count)
  );

  initial clock = 1'b0;

  always #(clock_period / 2) clock = ~clock;

  // Fibonacci LFSR, taps 32 22 2 1, one step per bit taken
  function automatic logic [31:0] random_bits(input int width);
    logic [31:0] value;
    logic        feedback;
    value = '0;
    for (int i = 0; i < width; i++) begin
      feedback   = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
      lfsr_state = {lfsr_state[30:0], feedback};
      value      = {value[30:0], feedback};
    end
    return value;
  endfunction

  function automatic logic [`PRF_TAG_SIZE-1:0] random_tag();
    return `PRF_TAG_SIZE'(random_bits(`PRF_TAG_SIZE));
  endfunction

  function automatic mem_uop_t make_uop(
    input logic                     is_store,
    input logic                     rs1_wait,
    input logic [`PRF_TAG_SIZE-1:0] rs1_tag,
    input logic                     rs2_wait,
    input logic [`PRF_TAG_SIZE-1:0] rs2_tag
  );
    mem_uop_t uop;
    uop.valid    = 1'b1;
    uop.is_store = is_store;
    uop.rs1_wait = rs1_wait;
    uop.rs1_tag  = rs1_tag;
    uop.rs2_wait = rs2_wait;
    uop.rs2_tag  = rs2_tag;
    uop.rob_id   = `ROB_ID_SIZE'(random_bits(`ROB_ID_SIZE));
    return uop;
  endfunction

  // Both operands already available
  function automatic mem_uop_t independent_uop(input logic is_store);
    return make_uop(is_store, 1'b0, random_tag(), 1'b0, random_tag());
  endfunction

  task automatic check_value(input string test_name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (expected !== actual) begin
      $display("Fail %s: expected %0h, actual %0h", test_name, expected, actual);
      $display("Test failed");
      $fatal(1, "Mismatch in %s", test_name);
    end
  endtask

  // Check the issue port mid-cycle, then move to the next drive point with idle inputs
  task automatic finish_cycle(input string test_name, input mem_uop_t expected);
    @(negedge clock);
    if (expected.valid) begin
      check_value(test_name, expected, issue_uop);
    end else begin
      check_value(test_name, 0, issue_uop.valid);
    end
    @(posedge clock);
    #1;
    dispatch_uop = '0;
    ctb          = '0;
  endtask

  task automatic reset_idle();
    repeat (5) begin
      check_value("reset_idle", 0, iq_full);
      finish_cycle("reset_idle", '0);
    end
  endtask

  task automatic in_order_loads();
    mem_uop_t loads [6];
    foreach (loads[i]) begin
      loads[i] = independent_uop(1'b0);
    end
    dispatch_uop[0] = loads[0];
    dispatch_uop[1] = loads[1];
    finish_cycle("in_order_loads", '0);
    dispatch_uop[0] = loads[2];
    dispatch_uop[1] = loads[3];
    finish_cycle("in_order_loads", loads[0]);
    dispatch_uop[0] = loads[4];
    dispatch_uop[1] = loads[5];
    finish_cycle("in_order_loads", loads[1]);
    for (int i = 2; i < 6; i++) begin
      finish_cycle("in_order_loads", loads[i]);
    end
    finish_cycle("in_order_loads", '0);
  endtask

  task automatic wakeup_order();
    logic [`PRF_TAG_SIZE-1:0] tag;
    mem_uop_t                 waiting;
    mem_uop_t                 younger;
    tag     = random_tag();
    waiting = make_uop(1'b0, 1'b1, tag, 1'b0, random_tag());
    younger = independent_uop(1'b0);
    dispatch_uop[0] = waiting;
    dispatch_uop[1] = younger;
    finish_cycle("wakeup_order", '0);
    finish_cycle("wakeup_order", younger);
    repeat (2) finish_cycle("wakeup_order", '0);
    ctb[0].valid = 1'b1;
    ctb[0].tag   = tag;
    finish_cycle("wakeup_order", '0);
    finish_cycle("wakeup_order", waiting);
    finish_cycle("wakeup_order", '0);
  endtask

  task automatic store_ordering();
    logic [`PRF_TAG_SIZE-1:0] tag;
    mem_uop_t                 waiting;
    mem_uop_t                 store;
    mem_uop_t                 load;
    tag     = random_tag();
    waiting = make_uop(1'b0, 1'b0, random_tag(), 1'b1, tag);
    store   = independent_uop(1'b1);
    load    = independent_uop(1'b0);
    dispatch_uop[0] = waiting;
    dispatch_uop[1] = store;
    finish_cycle("store_ordering", '0);
    // Store is ready but an older load is still waiting
    dispatch_uop[0] = load;
    finish_cycle("store_ordering", '0);
    finish_cycle("store_ordering", load);
    ctb[1].valid = 1'b1;
    ctb[1].tag   = tag;
    finish_cycle("store_ordering", '0);
    finish_cycle("store_ordering", waiting);
    finish_cycle("store_ordering", store);
    finish_cycle("store_ordering", '0);
  endtask

  task automatic busy_fill_drain();
    mem_uop_t ops [7];
    foreach (ops[i]) begin
      ops[i] = independent_uop(random_bits(1) != 0);
    end
    ex_busy = 1'b1;
    for (int i = 0; i < 7; i += 2) begin
      check_value("busy_fill_drain", 0, iq_full);
      dispatch_uop[0] = ops[i];
      if (i + 1 < 7) begin
        dispatch_uop[1] = ops[i+1];
      end
      finish_cycle("busy_fill_drain", '0);
    end
    // Seven occupied leaves one free slot
    repeat (3) begin
      check_value("busy_fill_drain", 1, iq_full);
      finish_cycle("busy_fill_drain", '0);
    end
    ex_busy = 1'b0;
    for (int i = 0; i < 7; i++) begin
      check_value("busy_fill_drain", (i == 0), iq_full);
      finish_cycle("busy_fill_drain", ops[i]);
    end
    check_value("busy_fill_drain", 0, iq_full);
    finish_cycle("busy_fill_drain", '0);
  endtask

  task automatic dual_lane_wakeup();
    logic [`PRF_TAG_SIZE-1:0] tag_a;
    logic [`PRF_TAG_SIZE-1:0] tag_b;
    logic [`PRF_TAG_SIZE-1:0] tag_c;
    mem_uop_t                 both;
    mem_uop_t                 late;
    tag_a = random_tag();
    tag_b = random_tag();
    tag_c = random_tag();
    both  = make_uop(1'b0, 1'b1, tag_a, 1'b1, tag_b);
    late  = make_uop(1'b1, 1'b0, random_tag(), 1'b1, tag_c);
    // Broadcast on both lanes while the micro-op is being dispatched
    dispatch_uop[0] = both;
    ctb[0].valid    = 1'b1;
    ctb[0].tag      = tag_a;
    ctb[1].valid    = 1'b1;
    ctb[1].tag      = tag_b;
    finish_cycle("dual_lane_wakeup", '0);
    finish_cycle("dual_lane_wakeup", both);
    dispatch_uop[1] = late;
    finish_cycle("dual_lane_wakeup", '0);
    finish_cycle("dual_lane_wakeup", '0);
    ctb[1].valid = 1'b1;
    ctb[1].tag   = tag_c;
    finish_cycle("dual_lane_wakeup", '0);
    finish_cycle("dual_lane_wakeup", late);
    finish_cycle("dual_lane_wakeup", '0);
  endtask

  initial begin
    reset        = 1'b1;
    ex_busy      = 1'b0;
    dispatch_uop = '0;
    ctb          = '0;
    repeat (2) @(posedge clock);
    #1;
    reset = 1'b0;

    reset_idle();
    in_order_loads();
    wakeup_order();
    store_ordering();
    busy_fill_drain();
    dual_lane_wakeup();

    $display("Test passed");
    $finish;
  end

  // Watchdog
  initial begin
    #(clock_period * (test_count * cycles_per_test + margin_cycles));
    $display("Watchdog expired before the tests completed");
    $display("Test failed");
    $fatal(1, "Simulation timed out");
  end

endmodule

`default_nettype wire

// ==== issue_queue_mem.f ====
+incdir+design
design/issue_queue_pkg.sv
design/issue_slot_mem.sv
design/issue_select_mem.sv
design/issue_queue_mem.sv
dv/issue_queue_mem_props.sv
dv/issue_queue_mem_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the memory issue queue testbench with Verilator, run it, judge the log
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --timescale 1ns/100ps \
  --top-module issue_queue_mem_tb \
  -f issue_queue_mem.f \
  -o issue_queue_mem_sim

./obj_dir/issue_queue_mem_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "Test failed" sim.log; then
  echo "run_sim: failure reported in sim.log"
  exit 1
fi
if ! grep -q "Test passed" sim.log; then
  echo "run_sim: simulation ended without a pass report"
  exit 1
fi
echo "run_sim: simulation passed"
